// ==== Bender.yml ====
package:
  name: mvu

sources:
  - files:
      - verilog/mvu_arch_pkg.sv
      - verilog/mvu_job_pkg.sv
      - verilog/mvu_delay.sv
      - verilog/mvu_plane_mem.sv
      - verilog/mvu_vvp.sv
      - verilog/mvu_shacc.sv
      - verilog/mvu_agu.sv
      - verilog/mvu_ctrl.sv
      - verilog/mvu_top.sv
  - target: test
    files:
      - tb/mvu_props.sv
      - tb/mvu_tb.sv

// ==== tb.f ====
verilog/mvu_arch_pkg.sv
verilog/mvu_job_pkg.sv
verilog/mvu_delay.sv
verilog/mvu_plane_mem.sv
verilog/mvu_vvp.sv
verilog/mvu_shacc.sv
verilog/mvu_agu.sv
verilog/mvu_ctrl.sv
verilog/mvu_top.sv
tb/mvu_props.sv
tb/mvu_tb.sv

// ==== tb/mvu_props.sv ====
// Bound assertions on the done, irq and busy behaviour of the matrix-vector unit
`timescale 1ns/1ps

module mvu_props (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic irq,
    input logic busy
);

    int fail_count = 0;                     // Assertions that have fired

    // Done is a single-cycle pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else begin
        $error("done stayed high for two cycles");
        fail_count++;
    end

    // The interrupt only comes up with a finished job
    irq_rises_with_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> done
    ) else begin
        $error("irq rose without done");
        fail_count++;
    end

    // Pipeline drain keeps busy up until done
    busy_before_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(busy)
    ) else begin
        $error("busy was low in the cycle before done");
        fail_count++;
    end

endmodule

bind mvu_top mvu_props props (
    .clk   (clk),
    .rst_n (rst_n),
    .done  (done),
    .irq   (irq),
    .busy  (busy)
);

// ==== tb/mvu_tb.sv ====
// Table-driven testbench that runs dot-product jobs through the matrix-vector unit
`timescale 1ns/1ps

module mvu_tb;
    import mvu_arch_pkg::*;
    import mvu_job_pkg::*;

    localparam int N_FIXED = 6;
    localparam int N_RAND = 6;
    localparam int N_JOBS = N_FIXED + N_RAND;
    localparam int TIMEOUT = 64;                // Cycles allowed per wait

    typedef logic [N_ELEM-1:0][MAX_PREC-1:0] nibbles_t;    // Element k in nibble k

    typedef struct packed {
        prec_t    iprec;
        prec_t    wprec;
        logic     isigned;
        logic     wsigned;
        addr_t    ibase;
        addr_t    wbase;
        logic     poke;                         // Extra start during the job
        nibbles_t xv;
        nibbles_t wv;
        acc_t     exp_val;
    } job_t;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   wrd_en;
    addr_t  wrd_addr;
    plane_t wrd_word;
    logic   wrw_en;
    addr_t  wrw_addr;
    plane_t wrw_word;
    logic   start;
    prec_t  iprec;
    prec_t  wprec;
    addr_t  ibase;
    addr_t  wbase;
    logic   isigned;
    logic   wsigned;
    acc_t   result;
    logic   done;
    logic   irq;
    logic   busy;

    job_t jobs [N_JOBS];
    int   seed = 32'hc3db;
    int   errors = 0;
    int   checks = 0;

    always #4 clk = ~clk;

    mvu_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wrd_en   (wrd_en),
        .wrd_addr (wrd_addr),
        .wrd_word (wrd_word),
        .wrw_en   (wrw_en),
        .wrw_addr (wrw_addr),
        .wrw_word (wrw_word),
        .start    (start),
        .iprec    (iprec),
        .wprec    (wprec),
        .ibase    (ibase),
        .wbase    (wbase),
        .isigned  (isigned),
        .wsigned  (wsigned),
        .result   (result),
        .done     (done),
        .irq      (irq),
        .busy     (busy)
    );

    task automatic check_acc(input string name, input acc_t got, input acc_t exp_val);
        checks++;
        if (got !== exp_val) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp_val);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        checks++;
        if (got !== exp_val) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp_val);
        end
    endtask

    function automatic job_t make_job(input int ip, input int wp, input logic isg,
                                      input logic wsg, input int ib, input int wb,
                                      input logic poke, input nibbles_t xv,
                                      input nibbles_t wv, input int exp_val);
        job_t j;
        j.iprec   = prec_t'(ip);
        j.wprec   = prec_t'(wp);
        j.isigned = isg;
        j.wsigned = wsg;
        j.ibase   = addr_t'(ib);
        j.wbase   = addr_t'(wb);
        j.poke    = poke;
        j.xv      = xv;
        j.wv      = wv;
        j.exp_val = acc_t'(exp_val);
        return j;
    endfunction

    // Value of one element at its precision and signedness
    function automatic int elem_val(input logic [MAX_PREC-1:0] nib, input prec_t prec,
                                    input logic sgn);
        int v;
        v = int'(nib) & ((1 << prec) - 1);
        if (sgn && ((v >> (prec - 1)) & 1)) begin
            v = v - (1 << prec);                // Two's complement MSB
        end
        return v;
    endfunction

    function automatic acc_t dot_ref(input job_t j);
        int sum;
        sum = 0;
        for (int k = 0; k < N_ELEM; k++) begin
            sum += elem_val(j.xv[k], j.iprec, j.isigned) * elem_val(j.wv[k], j.wprec, j.wsigned);
        end
        return acc_t'(sum);
    endfunction

    function automatic plane_t plane_of(input nibbles_t v, input int b);
        plane_t p;
        for (int k = 0; k < N_ELEM; k++) begin
            p[k] = v[k][b];                     // Bit b of element k
        end
        return p;
    endfunction

    task automatic build_table();
        job_t j;
        jobs[0] = make_job(1, 1, 0, 0, 0, 0, 0, 32'h1011_0111, 32'h1101_1011, 4);
        jobs[1] = make_job(4, 4, 0, 0, 2, 8, 1, 32'hFEDC_BA98, 32'h1234_5678, 372);
        jobs[2] = make_job(2, 3, 0, 0, 4, 5, 0, 32'h3210_3210, 32'h7654_3210, 52);
        jobs[3] = make_job(4, 4, 1, 1, 10, 13, 1, 32'h8F17_9E20, 32'h79F1_2E83, -69);
        jobs[4] = make_job(3, 2, 1, 0, 7, 3, 0, 32'h7654_3210, 32'h3213_2103, -14);
        jobs[5] = make_job(4, 3, 0, 1, 14, 15, 0, 32'h5A3C_0F96, 32'h3456_7012, -37);
        for (int n = N_FIXED; n < N_JOBS; n++) begin
            j.iprec   = prec_t'(($random(seed) & 3) + 1);
            j.wprec   = prec_t'(($random(seed) & 3) + 1);
            j.isigned = 1'($random(seed) & 1);
            j.wsigned = 1'($random(seed) & 1);
            j.ibase   = addr_t'($random(seed) & 15);
            j.wbase   = addr_t'($random(seed) & 15);
            j.poke    = (n == N_JOBS - 1);
            j.xv      = $random(seed);
            j.wv      = $random(seed);
            j.exp_val = dot_ref(j);
            jobs[n]   = j;
        end
    endtask

    task automatic load_planes(input job_t j);
        for (int b = 0; b < MAX_PREC; b++) begin
            @(posedge clk);
            wrd_en   <= (b < j.iprec);
            wrd_addr <= j.ibase + addr_t'(b);   // Wraps past the top address
            wrd_word <= plane_of(j.xv, b);
            wrw_en   <= (b < j.wprec);
            wrw_addr <= j.wbase + addr_t'(b);
            wrw_word <= plane_of(j.wv, b);
        end
        @(posedge clk);
        wrd_en <= 1'b0;
        wrw_en <= 1'b0;
    endtask

    task automatic run_job(input int n);
        job_t j;
        acc_t prev_val;
        int   exp_cycles;
        int   cycles;
        int   err_before;
        logic got_done;
        logic poke_now;
        j = jobs[n];
        prev_val = (n > 0) ? jobs[n - 1].exp_val : acc_t'(0);
        exp_cycles = int'(j.iprec) * int'(j.wprec) + 3;
        err_before = errors;
        load_planes(j);
        @(negedge clk);
        check_bit("irq", irq, n > 0);           // Still set from the last job
        @(posedge clk);
        start   <= 1'b1;
        iprec   <= j.iprec;
        wprec   <= j.wprec;
        ibase   <= j.ibase;
        wbase   <= j.wbase;
        isigned <= j.isigned;
        wsigned <= j.wsigned;
        cycles   = 0;
        got_done = 1'b0;
        while (!got_done && cycles < TIMEOUT) begin
            @(posedge clk);
            poke_now = j.poke && (cycles == 2);
            start <= poke_now;
            iprec <= poke_now ? prec_t'(1) : j.iprec;
            wprec <= poke_now ? prec_t'(1) : j.wprec;
            ibase <= poke_now ? ~j.ibase : j.ibase;
            @(negedge clk);
            cycles++;
            got_done = done;
            if (cycles <= exp_cycles) begin
                check_bit("busy", busy, 1'b1);
            end
            if (cycles == 1) begin
                check_bit("irq", irq, 1'b0);
            end
            if (!got_done) begin
                check_acc("result", result, prev_val);    // Previous job's sum until done
            end
        end
        if (!got_done) begin
            errors++;
            $display("case %0d: no done pulse within %0d cycles", n, TIMEOUT);
        end else begin
            if (cycles != exp_cycles) begin
                errors++;
                $display("case %0d: done came %0d cycles after start, expected %0d",
                         n, cycles, exp_cycles);
            end
            check_acc("result", result, j.exp_val);
            check_bit("irq", irq, 1'b1);
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_bit("irq", irq, 1'b1);
            check_bit("busy", busy, 1'b0);
            check_acc("result", result, j.exp_val);    // Held after done
        end
        $display("case %0d: prec %0dx%0d signed %b%b base %0d/%0d result 0x%h %s",
                 n, j.iprec, j.wprec, j.isigned, j.wsigned, j.ibase, j.wbase, result,
                 (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int err_before;
        rst_n    = 1'b0;
        wrd_en   = 1'b0;
        wrd_addr = '0;
        wrd_word = '0;
        wrw_en   = 1'b0;
        wrw_addr = '0;
        wrw_word = '0;
        start    = 1'b0;
        iprec    = prec_t'(1);
        wprec    = prec_t'(1);
        ibase    = '0;
        wbase    = '0;
        isigned  = 1'b0;
        wsigned  = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        err_before = errors;
        check_bit("done", done, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_acc("result", result, '0);
        $display("reset: %s", (errors == err_before) ? "ok" : "FAILED");
        for (int n = 0; n < N_JOBS; n++) begin
            run_job(n);
        end
        $display("jobs %0d, checks %0d, errors %0d, assertion failures %0d",
                 N_JOBS, checks, errors, uut.props.fail_count);
        if (errors == 0 && uut.props.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/mvu_agu.sv ====
// Zig-zag bit-plane address generator for the data and weight memories
`timescale 1ns/1ps

module mvu_agu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clr,
    input  logic                en,
    input  mvu_job_pkg::prec_t  iprec,
    input  mvu_job_pkg::prec_t  wprec,
    input  mvu_job_pkg::addr_t  ibase,
    input  mvu_job_pkg::addr_t  wbase,
    output mvu_job_pkg::addr_t  iaddr,
    output mvu_job_pkg::addr_t  waddr,
    output logic                imsb,
    output logic                wmsb,
    output logic                first,
    output logic                shift,
    output logic                last
);
    import mvu_job_pkg::*;

    bitidx_t               wb_q;
    bitidx_t               ib_q;
    logic                  fresh_q;         // Sitting on the opening pair
    bitidx_t               wtop;
    bitidx_t               itop;
    bitidx_t               wb;
    bitidx_t               ib;
    bitidx_t               wb_nxt;
    bitidx_t               ib_nxt;
    logic [$bits(prec_t)-1:0] sig;          // Significance wb + ib
    logic [$bits(prec_t)-1:0] sig_nxt;
    logic                  at_last;

    assign wtop = bitidx_t'(wprec - 1);
    assign itop = bitidx_t'(iprec - 1);

    // Precisions are latched after clr, so the opening pair comes from them directly
    assign wb = fresh_q ? wtop : wb_q;
    assign ib = fresh_q ? itop : ib_q;

    assign sig     = {1'b0, wb} + {1'b0, ib};
    assign at_last = (wb == '0) && (ib == '0);

    always_comb begin
        sig_nxt = sig - 1'b1;
        if (ib != itop && wb != '0) begin
            wb_nxt = wb - 1'b1;                // Same significance, next lower wb
            ib_nxt = ib + 1'b1;
        end else if (sig_nxt > {1'b0, wtop}) begin
            wb_nxt = wtop;                      // Lower significance, top weight bit
            ib_nxt = bitidx_t'(sig_nxt - {1'b0, wtop});
        end else begin
            wb_nxt = bitidx_t'(sig_nxt);
            ib_nxt = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fresh_q <= 1'b1;
            wb_q    <= '0;
            ib_q    <= '0;
        end else if (clr) begin
            fresh_q <= 1'b1;
        end else if (en && !at_last) begin
            fresh_q <= 1'b0;
            wb_q    <= wb_nxt;
            ib_q    <= ib_nxt;
        end
    end

    assign iaddr = ibase + addr_t'(ib);     // Wraps modulo the depth
    assign waddr = wbase + addr_t'(wb);
    assign imsb  = (ib == itop);
    assign wmsb  = (wb == wtop);

    // A pair opens its significance when wb is at its ceiling
    assign first = en && fresh_q;
    assign shift = en && !fresh_q && (wb == wtop || ib == '0);
    assign last  = en && at_last;

endmodule

// ==== verilog/mvu_arch_pkg.sv ====
// Architecture sizes and pipeline latencies of the bit-serial matrix-vector unit
package mvu_arch_pkg;

    // Vector geometry
    localparam int N_ELEM = 8;              // Elements per vector
    localparam int MAX_PREC = 4;            // Largest operand precision in bits

    // Plane memories
    localparam int MEM_DEPTH = 16;          // Planes per memory
    localparam int MEM_RD_LATENCY = 1;      // Address to read data

    // Popcount stage
    localparam int VVP_STAGES = 1;          // Registers inside the vector product

    // Address to accumulator update, the last cycle is the accumulator itself
    localparam int PIPE_DEPTH = MEM_RD_LATENCY + VVP_STAGES + 1;

    // Datapath widths
    localparam int ACC_W = 16;              // Signed accumulator
    localparam int TERM_W = 5;              // Popcount of 8 plus sign

endpackage

// ==== verilog/mvu_ctrl.sv ====
// Job controller that latches the job settings, runs the plane walk and flags completion
`timescale 1ns/1ps

module mvu_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  mvu_job_pkg::prec_t  iprec,
    input  mvu_job_pkg::prec_t  wprec,
    input  mvu_job_pkg::addr_t  ibase,
    input  mvu_job_pkg::addr_t  wbase,
    input  logic                isigned,
    input  logic                wsigned,
    input  logic                last,
    input  logic                done,
    output logic                run,
    output logic                agu_clr,
    output mvu_job_pkg::prec_t  iprec_q,
    output mvu_job_pkg::prec_t  wprec_q,
    output mvu_job_pkg::addr_t  ibase_q,
    output mvu_job_pkg::addr_t  wbase_q,
    output logic                isigned_q,
    output logic                wsigned_q,
    output logic                busy,
    output logic                irq
);
    import mvu_job_pkg::*;

    ctrl_state_t state_q;
    logic        accept;                    // Start taken for a new job
    logic        drain_q;                   // Pipeline still emptying
    logic        irq_q;

    assign accept  = start && !busy;       // Starts during a job are dropped
    assign agu_clr = accept;
    assign run     = (state_q == RUN);
    assign busy    = run || drain_q;
    assign irq     = irq_q || done;        // Rises in the done cycle itself

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (accept) state_q <= RUN;
                RUN:  if (last) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Drain lasts from the closing pair until the delayed done comes back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_q <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (run && last) begin
                drain_q <= 1'b1;
            end else if (done) begin
                drain_q <= 1'b0;
            end
            if (done) begin
                irq_q <= 1'b1;
            end else if (accept) begin
                irq_q <= 1'b0;                 // Cleared by the next job
            end
        end
    end

    // Job settings, only sampled with an accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            iprec_q   <= iprec;
            wprec_q   <= wprec;
            ibase_q   <= ibase;
            wbase_q   <= wbase;
            isigned_q <= isigned;
            wsigned_q <= wsigned;
        end
    end

endmodule

// ==== verilog/mvu_delay.sv ====
// Clearable shift register that delays one control bit by N cycles
`timescale 1ns/1ps

module mvu_delay #(
    parameter int N = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in,
    output logic out
);
    logic [N-1:0] stage_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= in;
            for (int k = 1; k < N; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign out = stage_q[N-1];

endmodule

// ==== verilog/mvu_job_pkg.sv ====
// Job-level vector types and controller state encoding of the matrix-vector unit
package mvu_job_pkg;

    import mvu_arch_pkg::*;

    // One bit plane, bit k belongs to element k
    typedef logic [N_ELEM-1:0] plane_t;

    // Plane memory address, wraps modulo the depth
    typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t;

    // Precision as the real bit count 1..MAX_PREC
    typedef logic [$clog2(MAX_PREC+1)-1:0] prec_t;

    // Bit index inside one precision
    typedef logic [$clog2(MAX_PREC)-1:0] bitidx_t;

    // Signed plane-pair term and the signed accumulator
    typedef logic signed [TERM_W-1:0] term_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Job controller states
    typedef enum logic {
        IDLE,
        RUN
    } ctrl_state_t;

endpackage

// ==== verilog/mvu_plane_mem.sv ====
// Bit-plane memory with a host write port and a registered read port
`timescale 1ns/1ps

module mvu_plane_mem #(
    parameter int DEPTH = mvu_arch_pkg::MEM_DEPTH
) (
    input  logic                clk,
    input  logic                wr_en,
    input  mvu_job_pkg::addr_t  wr_addr,
    input  mvu_job_pkg::plane_t wr_word,
    input  mvu_job_pkg::addr_t  rd_addr,
    output mvu_job_pkg::plane_t rd_word
);
    import mvu_job_pkg::*;

    plane_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;           // Host plane write
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_addr];
    end

endmodule

// ==== verilog/mvu_shacc.sv ====
// Shift-accumulator that folds plane-pair terms into the dot product
`timescale 1ns/1ps

module mvu_shacc (
    input  logic                clk,
    input  logic                rst_n,
    input  mvu_job_pkg::term_t  term,
    input  logic                acc_en,
    input  logic                load,
    input  logic                shift,
    input  logic                done,
    output mvu_job_pkg::acc_t   result
);
    import mvu_job_pkg::*;

    acc_t acc_q;
    acc_t result_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (acc_en) begin
            if (load) begin
                acc_q <= acc_t'(term);                     // Opening pair
            end else if (shift) begin
                acc_q <= (acc_q <<< 1) + acc_t'(term);     // Significance dropped
            end else begin
                acc_q <= acc_q + acc_t'(term);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (done) begin
            result_q <= acc_q;
        end
    end

    // The finished sum is already in acc_q during the done cycle
    assign result = done ? acc_q : result_q;

endmodule

// ==== verilog/mvu_top.sv ====
// Matrix-vector unit top level joining the job controller and the bit-serial datapath
`timescale 1ns/1ps

module mvu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wrd_en,
    input  mvu_job_pkg::addr_t  wrd_addr,
    input  mvu_job_pkg::plane_t wrd_word,
    input  logic                wrw_en,
    input  mvu_job_pkg::addr_t  wrw_addr,
    input  mvu_job_pkg::plane_t wrw_word,
    input  logic                start,
    input  mvu_job_pkg::prec_t  iprec,
    input  mvu_job_pkg::prec_t  wprec,
    input  mvu_job_pkg::addr_t  ibase,
    input  mvu_job_pkg::addr_t  wbase,
    input  logic                isigned,
    input  logic                wsigned,
    output mvu_job_pkg::acc_t   result,
    output logic                done,
    output logic                irq,
    output logic                busy
);
    import mvu_arch_pkg::*;
    import mvu_job_pkg::*;

    logic    run;
    logic    agu_clr;
    prec_t   iprec_q;
    prec_t   wprec_q;
    addr_t   ibase_q;
    addr_t   wbase_q;
    logic    isigned_q;
    logic    wsigned_q;
    addr_t   iaddr;
    addr_t   waddr;
    logic    imsb;
    logic    wmsb;
    logic    first;
    logic    shift;
    logic    last;
    plane_t  iplane;
    plane_t  wplane;
    logic    imsb_d;                        // Aligned with read data
    logic    wmsb_d;
    term_t   term;
    logic    acc_en;                        // Aligned with the term
    logic    load;
    logic    shift_d;

    mvu_ctrl ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .iprec     (iprec),
        .wprec     (wprec),
        .ibase     (ibase),
        .wbase     (wbase),
        .isigned   (isigned),
        .wsigned   (wsigned),
        .last      (last),
        .done      (done),
        .run       (run),
        .agu_clr   (agu_clr),
        .iprec_q   (iprec_q),
        .wprec_q   (wprec_q),
        .ibase_q   (ibase_q),
        .wbase_q   (wbase_q),
        .isigned_q (isigned_q),
        .wsigned_q (wsigned_q),
        .busy      (busy),
        .irq       (irq)
    );

    mvu_agu agu (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (agu_clr),
        .en    (run),
        .iprec (iprec_q),
        .wprec (wprec_q),
        .ibase (ibase_q),
        .wbase (wbase_q),
        .iaddr (iaddr),
        .waddr (waddr),
        .imsb  (imsb),
        .wmsb  (wmsb),
        .first (first),
        .shift (shift),
        .last  (last)
    );

    mvu_plane_mem #(.DEPTH(MEM_DEPTH)) dmem (
        .clk     (clk),
        .wr_en   (wrd_en),
        .wr_addr (wrd_addr),
        .wr_word (wrd_word),
        .rd_addr (iaddr),
        .rd_word (iplane)
    );

    mvu_plane_mem #(.DEPTH(MEM_DEPTH)) wmem (
        .clk     (clk),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (waddr),
        .rd_word (wplane)
    );

    // MSB flags follow the memory read
    mvu_delay #(.N(MEM_RD_LATENCY)) imsb_dly (.clk(clk), .rst_n(rst_n), .in(imsb), .out(imsb_d));
    mvu_delay #(.N(MEM_RD_LATENCY)) wmsb_dly (.clk(clk), .rst_n(rst_n), .in(wmsb), .out(wmsb_d));

    mvu_vvp vvp (
        .clk     (clk),
        .rst_n   (rst_n),
        .iplane  (iplane),
        .wplane  (wplane),
        .imsb_d  (imsb_d),
        .wmsb_d  (wmsb_d),
        .isigned (isigned_q),
        .wsigned (wsigned_q),
        .term    (term)
    );

    // Accumulator controls follow memory and popcount
    mvu_delay #(.N(MEM_RD_LATENCY + VVP_STAGES)) run_dly (
        .clk(clk), .rst_n(rst_n), .in(run), .out(acc_en)
    );
    mvu_delay #(.N(MEM_RD_LATENCY + VVP_STAGES)) first_dly (
        .clk(clk), .rst_n(rst_n), .in(first), .out(load)
    );
    mvu_delay #(.N(MEM_RD_LATENCY + VVP_STAGES)) shift_dly (
        .clk(clk), .rst_n(rst_n), .in(shift), .out(shift_d)
    );

    // Done returns once the closing pair has been accumulated
    mvu_delay #(.N(PIPE_DEPTH)) done_dly (.clk(clk), .rst_n(rst_n), .in(last), .out(done));

    mvu_shacc shacc (
        .clk    (clk),
        .rst_n  (rst_n),
        .term   (term),
        .acc_en (acc_en),
        .load   (load),
        .shift  (shift_d),
        .done   (done),
        .result (result)
    );

endmodule

// ==== verilog/mvu_vvp.sv ====
// Bit-plane vector product of AND, popcount and sign correction, one register deep
`timescale 1ns/1ps

module mvu_vvp (
    input  logic                clk,
    input  logic                rst_n,
    input  mvu_job_pkg::plane_t iplane,
    input  mvu_job_pkg::plane_t wplane,
    input  logic                imsb_d,
    input  logic                wmsb_d,
    input  logic                isigned,
    input  logic                wsigned,
    output mvu_job_pkg::term_t  term
);
    import mvu_arch_pkg::*;
    import mvu_job_pkg::*;

    plane_t              hits;
    logic [TERM_W-2:0]   cnt;               // 0..N_ELEM
    logic                neg;

    assign hits = iplane & wplane;

    // An MSB plane of a signed operand has negative weight
    assign neg = (isigned && imsb_d) ^ (wsigned && wmsb_d);

    always_comb begin
        cnt = '0;
        for (int k = 0; k < N_ELEM; k++) begin
            cnt = cnt + hits[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            term <= '0;
        end else begin
            term <= neg ? -term_t'(cnt) : term_t'(cnt);
        end
    end

endmodule
